// File: Makefile
# Verilator build and run for the Time Pilot I/O glue

VERILATOR ?= verilator
TOP       ?= timeplt_io_tb
FILELIST  ?= timeplt_io_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Verdict comes from the log
run: $(SIM)
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/timeplt_io_properties.sv
// PLL port checks for the underclock sequencer, attached by bind
`timescale 1ns/1ps

module timeplt_io_properties import timeplt_pkg::*; (
	input logic      CLK_49M,
	input logic      rst,
	input logic      pll_waitrequest,
	input pll_wr_t   pll_wr,
	input seq_step_e step
);

	// Read back by the testbench at the end of the run
	int fail_count;

	initial fail_count = 0;

	// ==================================================
	// Port protocol
	// ==================================================
	// Stalled transfer keeps address and data
	hold_during_stall: assert property (@(posedge CLK_49M) disable iff (rst)
		pll_waitrequest |=> $stable(pll_wr.address) && $stable(pll_wr.data))
	else begin
		$error("PLL address or data moved while waitrequest was high");
		fail_count++;
	end

	// Accepted write is a single beat, the next step never writes
	single_accept: assert property (@(posedge CLK_49M) disable iff (rst)
		(pll_wr.write && !pll_waitrequest) |=> !pll_wr.write)
	else begin
		$error("PLL write stayed high after it was accepted");
		fail_count++;
	end

	// Reset leaves the port quiet and the sequencer idle
	quiet_after_reset: assert property (@(posedge CLK_49M)
		rst |=> !pll_wr.write && step == IDLE)
	else begin
		$error("PLL write or sequencer step not cleared by reset");
		fail_count++;
	end

endmodule

bind pll_underclock_seq timeplt_io_properties u_pll_props (
	.CLK_49M         (CLK_49M),
	.rst             (rst),
	.pll_waitrequest (pll_waitrequest),
	.pll_wr          (pll_wr),
	.step            (step)
);

// File: dv/timeplt_io_tb.sv
// Testbench for the Time Pilot I/O glue, table of cases over keyboard, joystick, DIP, colour, PLL
`timescale 1ns/1ps
`include "timeplt_macros.svh"

module timeplt_io_tb import timeplt_pkg::*; ();

	typedef enum logic [2:0] {K_RST, K_KEY, K_JOY, K_DIP, K_RGB, K_UC} kind_e;

	// One table row, only the fields of its kind are used
	typedef struct packed {
		kind_e       kind;
		ps2_key_t    key;
		joystick_t   j0;
		joystick_t   j1;
		download_t   dl;
		rgb5_t       rgb;
		logic        uc;
		logic [31:0] stall;
		cabinet_t    exp_cab;
		logic [15:0] exp_dip;
		rgb8_t       exp_rgb;
	} entry_t;

	logic        CLK_49M;
	logic        rst;
	ps2_key_t    ps2_key;
	joystick_t   joy0;
	joystick_t   joy1;
	download_t   dl;
	logic        underclock;
	logic        pll_waitrequest;
	rgb5_t       rgb_in;
	cabinet_t    cab;
	logic [15:0] dip_sw;
	pll_wr_t     pll_wr;
	rgb8_t       rgb_out;

	entry_t      tbl[$];
	string       names[$];
	bit          tbl_ready;
	bit          test_bad;
	int          n_pass;
	int          n_fail;
	int          assert_fails;
	logic [15:0] lfsr_state;

	timeplt_io_top u_dut (
		.CLK_49M         (CLK_49M),
		.rst             (rst),
		.ps2_key         (ps2_key),
		.joy0            (joy0),
		.joy1            (joy1),
		.dl              (dl),
		.underclock      (underclock),
		.pll_waitrequest (pll_waitrequest),
		.rgb_in          (rgb_in),
		.cab             (cab),
		.dip_sw          (dip_sw),
		.pll_wr          (pll_wr),
		.rgb_out         (rgb_out)
	);

	// 4 ns clock
	initial begin
		CLK_49M = 1'b0;
		forever #2 CLK_49M = ~CLK_49M;
	end

	// ==================================================
	// Stimulus helpers
	// ==================================================
	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_next_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hB400 : 16'h0000);
		return out;
	endfunction

	function automatic rgb5_t random_rgb();
		rgb5_t v;
		int    i;
		for (i = 0; i < 15; i++)
			v[i] = lfsr_next_bit();
		return v;
	endfunction

	// Resistor ladder level, one weight per set bit
	function automatic logic [7:0] ladder_level(input logic [4:0] lvl);
		logic [7:0] w [5];
		logic [7:0] sum;
		int         i;
		w[0] = `COLOR_W0;
		w[1] = `COLOR_W1;
		w[2] = `COLOR_W2;
		w[3] = `COLOR_W3;
		w[4] = `COLOR_W4;
		sum  = 8'h00;
		for (i = 0; i < 5; i++)
			if (lvl[i])
				sum = sum + w[i];
		return sum;
	endfunction

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_cab(input string name, input cabinet_t exp, input cabinet_t act);
		if (act !== exp) begin
			$display("[FAIL] %s cab expected %h actual %h", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_dip(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s dip_sw expected %h actual %h", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_rgb(input string name, input rgb8_t exp, input rgb8_t act);
		if (act !== exp) begin
			$display("[FAIL] %s rgb_out expected %h actual %h", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	task automatic check_pll_wr(input string name, input pll_wr_t exp, input pll_wr_t act);
		if (act !== exp) begin
			$display("[FAIL] %s pll_wr expected %h actual %h", name, exp, act);
			test_bad = 1'b1;
		end
	endtask

	// ==================================================
	// Test table
	// ==================================================
	task automatic add_entry(input string name, input entry_t e);
		names.push_back(name);
		tbl.push_back(e);
	endtask

	task automatic add_key(input string name, input ps2_key_t key, input cabinet_t exp);
		entry_t e;
		e         = '0;
		e.kind    = K_KEY;
		e.key     = key;
		e.exp_cab = exp;
		add_entry(name, e);
	endtask

	task automatic add_joy(input string name, input joystick_t j0, input joystick_t j1,
		input cabinet_t exp);
		entry_t e;
		e         = '0;
		e.kind    = K_JOY;
		e.j0      = j0;
		e.j1      = j1;
		e.exp_cab = exp;
		add_entry(name, e);
	endtask

	task automatic add_dip(input string name, input download_t beat, input logic [15:0] exp);
		entry_t e;
		e         = '0;
		e.kind    = K_DIP;
		e.dl      = beat;
		e.exp_dip = exp;
		add_entry(name, e);
	endtask

	task automatic add_rgb(input string name, input rgb5_t rgb, input rgb8_t exp);
		entry_t e;
		e         = '0;
		e.kind    = K_RGB;
		e.rgb     = rgb;
		e.exp_rgb = exp;
		add_entry(name, e);
	endtask

	task automatic add_uc(input string name, input logic uc, input logic [31:0] stall);
		entry_t e;
		e       = '0;
		e.kind  = K_UC;
		e.uc    = uc;
		e.stall = stall;
		add_entry(name, e);
	endtask

	task automatic build_table();
		entry_t e;
		rgb5_t  r;
		int     i;
		e      = '0;
		e.kind = K_RST;
		add_entry("reset_values", e);
		// Keyboard, toggle flips on every real event
		add_key("key1_press", {1'b1, 1'b1, 1'b0, `KEY_CODE_1}, 16'hEFFF);
		add_key("key1_release", {1'b0, 1'b0, 1'b0, `KEY_CODE_1}, 16'hFFFF);
		add_key("key_up_press", {1'b1, 1'b1, 1'b1, `KEY_CODE_UP}, 16'hFEEF);
		add_key("key_unknown", {1'b0, 1'b1, 1'b0, 8'h1C}, 16'hFEEF);
		// Same toggle as before, so no event
		add_key("key_no_toggle", {1'b0, 1'b0, 1'b1, `KEY_CODE_UP}, 16'hFEEF);
		add_key("key_up_release", {1'b1, 1'b0, 1'b1, `KEY_CODE_UP}, 16'hFFFF);
		add_key("key6_press", {1'b0, 1'b1, 1'b0, `KEY_CODE_6}, 16'h7FFF);
		add_key("key6_release", {1'b1, 1'b0, 1'b0, `KEY_CODE_6}, 16'hFFFF);
		add_key("key_ctrl_press", {1'b0, 1'b1, 1'b0, `KEY_CODE_CTRL}, 16'hFFF3);
		add_key("key_ctrl_release", {1'b1, 1'b0, 1'b0, `KEY_CODE_CTRL}, 16'hFFFF);
		// Joysticks
		add_joy("joy1_fire", 16'h0000, 16'h0010, 16'hFFFB);
		add_joy("joy0_start1_coin1", 16'h0060, 16'h0000, 16'hAFFF);
		add_joy("joy1_start1_coin1", 16'h0000, 16'h0060, 16'hAFFF);
		add_joy("joy1_start2_pause", 16'h0000, 16'h0180, 16'hDFFE);
		add_joy("joy0_right_up", 16'h0009, 16'h0000, 16'hF6FF);
		add_joy("joy_release", 16'h0000, 16'h0000, 16'hFFFF);
		// DIP bytes
		add_dip("dip_addr0", {1'b1, `DIP_INDEX, 25'd0, 8'hA5}, 16'hFF5A);
		add_dip("dip_addr1", {1'b1, `DIP_INDEX, 25'd1, 8'h3C}, 16'hC35A);
		add_dip("dip_addr2", {1'b1, `DIP_INDEX, 25'd2, 8'hFF}, 16'hC35A);
		add_dip("dip_other_index", {1'b1, 8'd253, 25'd0, 8'h00}, 16'hC35A);
		// Colour
		for (i = 0; i < 4; i++) begin
			r = random_rgb();
			add_rgb($sformatf("rgb_random%0d", i), r,
				{ladder_level(r.r), ladder_level(r.g), ladder_level(r.b)});
		end
		add_rgb("rgb_full_scale", '1, 24'hFFFFFF);
		// Underclock with waitrequest stall masks, bit n is cycle n
		add_uc("uc_raise", 1'b1, 32'h9A3C5E21);
		add_uc("uc_lower", 1'b0, 32'h5B0E6C93);
		add_uc("uc_raise_again", 1'b1, 32'h00000000);
		tbl_ready = 1'b1;
	endtask

	// Change the setting, then collect accepted writes under the stall mask
	task automatic run_underclock(input string name, input logic uc, input logic [31:0] stall);
		pll_wr_t exp [3];
		int      n_acc;
		int      cyc;
		int      tail;
		exp[0] = {1'b1, `PLL_ADDR_MODE, 32'd0};
		exp[1] = {1'b1, `PLL_ADDR_MFRAC, uc ? `PLL_MFRAC_UNDER : `PLL_MFRAC_NATIVE};
		exp[2] = {1'b1, `PLL_ADDR_START, 32'd0};
		n_acc  = 0;
		cyc    = 0;
		tail   = 0;
		@(posedge CLK_49M);
		#1 underclock = uc;
		// Ends 8 cycles after the start write, or at the cycle limit
		while (cyc < 60 && tail < 8) begin
			pll_waitrequest = stall[cyc[4:0]];
			#1;
			if (pll_wr.write && !pll_waitrequest) begin
				if (n_acc < 3) begin
					check_pll_wr(name, exp[n_acc], pll_wr);
				end else begin
					$display("Test %s: a PLL write came after the start write", name);
					test_bad = 1'b1;
				end
				n_acc++;
			end
			if (n_acc >= 3)
				tail++;
			@(posedge CLK_49M);
			#1;
			cyc++;
		end
		pll_waitrequest = 1'b0;
		if (n_acc < 3) begin
			$display("Test %s: only %0d of 3 PLL writes were accepted", name, n_acc);
			test_bad = 1'b1;
		end
	endtask

	// ==================================================
	// Watchdog
	// ==================================================
	initial begin
		wait (tbl_ready);
		repeat (tbl.size() * 64 + 200) @(posedge CLK_49M);
		$display("Timeout: the tests did not finish within the cycle limit");
		$display("** FAIL **");
		$finish;
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		entry_t e;
		int     i;
		rst             = 1'b1;
		ps2_key         = '0;
		joy0            = '0;
		joy1            = '0;
		dl              = '0;
		underclock      = 1'b0;
		pll_waitrequest = 1'b0;
		rgb_in          = '0;
		n_pass          = 0;
		n_fail          = 0;
		lfsr_state      = 16'd62;
		build_table();
		repeat (4) @(posedge CLK_49M);
		#1 rst = 1'b0;
		for (i = 0; i < tbl.size(); i++) begin
			e        = tbl[i];
			test_bad = 1'b0;
			case (e.kind)
				K_RST: begin
					check_cab(names[i], '1, cab);
					check_dip(names[i], '1, dip_sw);
					check_pll_wr(names[i], '0, pll_wr);
					check_rgb(names[i], '0, rgb_out);
				end
				// Register stage plus button stage
				K_KEY: begin
					@(posedge CLK_49M);
					#1 ps2_key = e.key;
					repeat (2) @(posedge CLK_49M);
					#1 check_cab(names[i], e.exp_cab, cab);
				end
				K_JOY: begin
					@(posedge CLK_49M);
					#1 joy0 = e.j0;
					joy1 = e.j1;
					@(posedge CLK_49M);
					#1 check_cab(names[i], e.exp_cab, cab);
				end
				// One-cycle write beat
				K_DIP: begin
					@(posedge CLK_49M);
					#1 dl = e.dl;
					@(posedge CLK_49M);
					#1 dl.wr = 1'b0;
					check_dip(names[i], e.exp_dip, dip_sw);
				end
				K_RGB: begin
					@(posedge CLK_49M);
					#1 rgb_in = e.rgb;
					@(posedge CLK_49M);
					#1 check_rgb(names[i], e.exp_rgb, rgb_out);
				end
				default: run_underclock(names[i], e.uc, e.stall);
			endcase
			if (test_bad) begin
				n_fail++;
				$display("Test %s failed", names[i]);
			end else begin
				n_pass++;
				$display("Test %s passed", names[i]);
			end
		end
		assert_fails = u_dut.u_pll_underclock_seq.u_pll_props.fail_count;
		if (assert_fails != 0)
			$display("PLL port assertions failed %0d times", assert_fails);
		$display("Tests run %0d, passed %0d, failed %0d", tbl.size(), n_pass, n_fail);
		if (n_fail == 0 && assert_fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: include/timeplt_macros.svh
// Time Pilot I/O constants for key codes, PLL reconfiguration, DIP loading and colour weights
`ifndef TIMEPLT_MACROS_SVH
`define TIMEPLT_MACROS_SVH

// ==================================================
// PS/2 set 2 scan codes for the cabinet keys
// ==================================================
`define KEY_CODE_1     8'h16
`define KEY_CODE_2     8'h1E
`define KEY_CODE_5     8'h2E
`define KEY_CODE_6     8'h36
`define KEY_CODE_9     8'h46
`define KEY_CODE_P     8'h4D
// Arrow keys arrive with the extended flag, which is not decoded
`define KEY_CODE_UP    8'h75
`define KEY_CODE_DOWN  8'h72
`define KEY_CODE_LEFT  8'h6B
`define KEY_CODE_RIGHT 8'h74
`define KEY_CODE_CTRL  8'h14

// PLL reconfiguration registers and fractional multiplier values
`define PLL_ADDR_MODE    6'd0
`define PLL_ADDR_MFRAC   6'd7
`define PLL_ADDR_START   6'd2
`define PLL_MFRAC_NATIVE 32'd3639383488
`define PLL_MFRAC_UNDER  32'd3262113561

// Download index carrying the DIP switch bytes
`define DIP_INDEX 8'd254

// Resistor ladder weights, bit 0 up to bit 4
`define COLOR_W0 8'h19
`define COLOR_W1 8'h24
`define COLOR_W2 8'h35
`define COLOR_W3 8'h40
`define COLOR_W4 8'h4D

`endif

// File: source/cabinet_input_mapper.sv
// Cabinet input mapper that merges held keyboard buttons with the joysticks into active-low inputs
`timescale 1ns/1ps

module cabinet_input_mapper import timeplt_pkg::*; (
	input  logic      CLK_49M,
	input  logic      rst,
	input  ps2_key_t  ps2_key,
	input  joystick_t joy0,
	input  joystick_t joy1,
	output cabinet_t  cab
);

	// Held key state where 1 means pressed
	typedef struct packed {
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic service;
		logic pause;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
	} key_btn_t;

	ps2_key_t  ps2_q;
	logic      toggle_prev;
	logic      key_event;
	key_btn_t  btn;
	key_btn_t  btn_next;
	joystick_t joy_any;
	cabinet_t  cab_next;

	// ==================================================
	// Keyboard event capture
	// ==================================================
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			ps2_q       <= '0;
			toggle_prev <= 1'b0;
		end else begin
			ps2_q       <= ps2_key;
			toggle_prev <= ps2_q.toggle;
		end
	end

	// Any flip of the toggle bit is one event
	assign key_event = ps2_q.toggle != toggle_prev;

	// Next button state where unknown codes leave the buttons as they are
	always_comb begin
		btn_next = btn;
		if (key_event) begin
			case (ps2_q.code)
				KEY_START1:  btn_next.start1  = ps2_q.pressed;
				KEY_START2:  btn_next.start2  = ps2_q.pressed;
				KEY_COIN1:   btn_next.coin1   = ps2_q.pressed;
				KEY_COIN2:   btn_next.coin2   = ps2_q.pressed;
				KEY_SERVICE: btn_next.service = ps2_q.pressed;
				KEY_PAUSE:   btn_next.pause   = ps2_q.pressed;
				KEY_UP:      btn_next.up      = ps2_q.pressed;
				KEY_DOWN:    btn_next.down    = ps2_q.pressed;
				KEY_LEFT:    btn_next.left    = ps2_q.pressed;
				KEY_RIGHT:   btn_next.right   = ps2_q.pressed;
				KEY_FIRE:    btn_next.fire    = ps2_q.pressed;
				default: ;
			endcase
		end
	end

	// ==================================================
	// Merge with joysticks
	// ==================================================
	// Start, coin and pause are shared by both sticks
	assign joy_any = joystick_t'(joy0 | joy1);

	always_comb begin
		cab_next.coin    = ~{btn_next.coin2, btn_next.coin1 | joy_any.coin1};
		cab_next.start   = ~{btn_next.start2 | joy_any.start2, btn_next.start1 | joy_any.start1};
		// Keyboard arrows drive both players
		cab_next.p1_joy  = ~{btn_next.right | joy0.right, btn_next.left | joy0.left,
			btn_next.down | joy0.down, btn_next.up | joy0.up};
		cab_next.p2_joy  = ~{btn_next.right | joy1.right, btn_next.left | joy1.left,
			btn_next.down | joy1.down, btn_next.up | joy1.up};
		cab_next.p1_fire = ~(btn_next.fire | joy0.fire);
		cab_next.p2_fire = ~(btn_next.fire | joy1.fire);
		cab_next.service = ~btn_next.service;
		cab_next.pause   = ~(btn_next.pause | joy_any.pause);
	end

	// Buttons and cabinet word share one stage
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			btn <= '0;
			cab <= '1;
		end else begin
			btn <= btn_next;
			cab <= cab_next;
		end
	end

endmodule

// File: source/color_weighting.sv
// Colour weighting, 5-bit channels to 8-bit levels through the resistor ladder weights
`timescale 1ns/1ps

module color_weighting import timeplt_pkg::*; (
	input  logic  CLK_49M,
	input  logic  rst,
	input  rgb5_t rgb_in,
	output rgb8_t rgb_out
);

	// Sum of the weights of all set bits
	function automatic logic [7:0] weigh(input logic [4:0] lvl);
		logic [7:0] acc;
		acc = '0;
		if (lvl[0])
			acc = acc + `COLOR_W0;
		if (lvl[1])
			acc = acc + `COLOR_W1;
		if (lvl[2])
			acc = acc + `COLOR_W2;
		if (lvl[3])
			acc = acc + `COLOR_W3;
		if (lvl[4])
			acc = acc + `COLOR_W4;
		return acc;
	endfunction

	// Full scale adds up to exactly FFh, no overflow
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			rgb_out <= '0;
		end else begin
			rgb_out.r <= weigh(rgb_in.r);
			rgb_out.g <= weigh(rgb_in.g);
			rgb_out.b <= weigh(rgb_in.b);
		end
	end

endmodule

// File: source/dip_switch_loader.sv
// DIP switch loader, captures the two switch bytes from the download stream
`timescale 1ns/1ps

module dip_switch_loader import timeplt_pkg::*; (
	input  logic        CLK_49M,
	input  logic        rst,
	input  download_t   dl,
	output logic [15:0] dip_sw
);

	logic [7:0] dip_lo;
	logic [7:0] dip_hi;
	logic       dip_hit;

	// Only addresses 0 and 1 of the DIP index land here
	assign dip_hit = dl.wr && (dl.index == `DIP_INDEX) && (dl.addr[24:1] == '0);

	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			dip_lo <= '0;
			dip_hi <= '0;
		end else if (dip_hit) begin
			if (dl.addr[0])
				dip_hi <= dl.data;
			else
				dip_lo <= dl.data;
		end
	end

	// Switches are active low on the board
	assign dip_sw = ~{dip_hi, dip_lo};

endmodule

// File: source/pll_underclock_seq.sv
// PLL underclock sequencer, reprograms the pixel PLL when the underclock setting changes
`timescale 1ns/1ps

module pll_underclock_seq import timeplt_pkg::*; (
	input  logic    CLK_49M,
	input  logic    rst,
	input  logic    underclock,
	input  logic    pll_waitrequest,
	output pll_wr_t pll_wr
);

	logic      uc_s1;
	logic      uc_s2;
	logic      uc_applied;
	seq_step_e step;

	// ==================================================
	// Setting filter and write sequence
	// ==================================================
	always_ff @(posedge CLK_49M) begin
		if (rst) begin
			uc_s1      <= 1'b0;
			uc_s2      <= 1'b0;
			uc_applied <= 1'b0;
			step       <= IDLE;
			pll_wr     <= '0;
		end else begin
			uc_s1 <= underclock;
			uc_s2 <= uc_s1;

			// Two equal samples that differ from what the PLL runs now
			if (step == IDLE && uc_s1 == uc_s2 && uc_s2 != uc_applied) begin
				step       <= MODE;
				uc_applied <= uc_s2;
			end

			// Stalled port holds step and the pending write as they are
			if (!pll_waitrequest) begin
				pll_wr.write <= 1'b0;
				if (step != IDLE)
					step <= seq_step_e'(step + 3'd1);
				case (step)
					MODE: begin
						pll_wr.write   <= 1'b1;
						pll_wr.address <= `PLL_ADDR_MODE;
						pll_wr.data    <= '0;
					end
					MFRAC: begin
						pll_wr.write   <= 1'b1;
						pll_wr.address <= `PLL_ADDR_MFRAC;
						pll_wr.data    <= uc_applied ? `PLL_MFRAC_UNDER : `PLL_MFRAC_NATIVE;
					end
					// Start write ends the sequence
					START: begin
						pll_wr.write   <= 1'b1;
						pll_wr.address <= `PLL_ADDR_START;
						pll_wr.data    <= '0;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// File: source/timeplt_io_top.sv
// Time Pilot I/O top, cabinet inputs, DIP switches, PLL underclock and colour output
`timescale 1ns/1ps

module timeplt_io_top import timeplt_pkg::*; (
	input  logic        CLK_49M,
	input  logic        rst,
	input  ps2_key_t    ps2_key,
	input  joystick_t   joy0,
	input  joystick_t   joy1,
	input  download_t   dl,
	input  logic        underclock,
	input  logic        pll_waitrequest,
	input  rgb5_t       rgb_in,
	output cabinet_t    cab,
	output logic [15:0] dip_sw,
	output pll_wr_t     pll_wr,
	output rgb8_t       rgb_out
);

	// ==================================================
	// Input side
	// ==================================================
	cabinet_input_mapper u_cabinet_input_mapper (
		.CLK_49M (CLK_49M),
		.rst     (rst),
		.ps2_key (ps2_key),
		.joy0    (joy0),
		.joy1    (joy1),
		.cab     (cab)
	);

	dip_switch_loader u_dip_switch_loader (
		.CLK_49M (CLK_49M),
		.rst     (rst),
		.dl      (dl),
		.dip_sw  (dip_sw)
	);

	// PLL management port runs on the pixel clock here
	pll_underclock_seq u_pll_underclock_seq (
		.CLK_49M         (CLK_49M),
		.rst             (rst),
		.underclock      (underclock),
		.pll_waitrequest (pll_waitrequest),
		.pll_wr          (pll_wr)
	);

	// Output side
	color_weighting u_color_weighting (
		.CLK_49M (CLK_49M),
		.rst     (rst),
		.rgb_in  (rgb_in),
		.rgb_out (rgb_out)
	);

endmodule

// File: source/timeplt_pkg.sv
// Shared types of the Time Pilot control and video glue
`include "timeplt_macros.svh"

package timeplt_pkg;

	// Keyboard event word, toggle flips once per event
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} ps2_key_t;

	// Host joystick word, bit 0 is right
	typedef struct packed {
		logic [6:0] spare;
		logic       pause;
		logic       start2;
		logic       coin1;
		logic       start1;
		logic       fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joystick_t;

	// ==================================================
	// Cabinet side, every bit active low
	// coin and start are {player 2, player 1}
	// joystick nibbles are {right, left, down, up}
	// ==================================================
	typedef struct packed {
		logic [1:0] coin;
		logic [1:0] start;
		logic [3:0] p1_joy;
		logic [3:0] p2_joy;
		logic       p1_fire;
		logic       p2_fire;
		logic       service;
		logic       pause;
	} cabinet_t;

	// Download stream beat
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} download_t;

	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb5_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb8_t;

	// PLL configuration port, write side
	typedef struct packed {
		logic        write;
		logic [5:0]  address;
		logic [31:0] data;
	} pll_wr_t;

	// Sequencer steps, encoded so that +1 walks the sequence and wraps to IDLE
	typedef enum logic [2:0] {
		IDLE, MODE, WAIT2, WAIT3, WAIT4, MFRAC, WAIT6, START
	} seq_step_e;

	typedef enum logic [7:0] {
		KEY_START1  = `KEY_CODE_1,
		KEY_START2  = `KEY_CODE_2,
		KEY_COIN1   = `KEY_CODE_5,
		KEY_COIN2   = `KEY_CODE_6,
		KEY_SERVICE = `KEY_CODE_9,
		KEY_PAUSE   = `KEY_CODE_P,
		KEY_UP      = `KEY_CODE_UP,
		KEY_DOWN    = `KEY_CODE_DOWN,
		KEY_LEFT    = `KEY_CODE_LEFT,
		KEY_RIGHT   = `KEY_CODE_RIGHT,
		KEY_FIRE    = `KEY_CODE_CTRL
	} key_code_e;

endpackage

// File: timeplt_io_top.f
+incdir+include
source/timeplt_pkg.sv
source/cabinet_input_mapper.sv
source/dip_switch_loader.sv
source/pll_underclock_seq.sv
source/color_weighting.sv
source/timeplt_io_top.sv
dv/timeplt_io_properties.sv
dv/timeplt_io_tb.sv
